/* pmp_unit.f */
+incdir+hdl
hdl/pmp_pkg.sv
hdl/pmp_region_match.sv
hdl/pmp_access_check.sv
hdl/pmp_csr_bank.sv
hdl/pmp_unit.sv
testbench/pmp_unit_sva.sv
testbench/pmp_unit_monitor.sv
testbench/pmp_unit_tb.sv

/* Bender.yml */
package:
  name: pmp_unit

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/pmp_pkg.sv
      - hdl/pmp_region_match.sv
      - hdl/pmp_access_check.sv
      - hdl/pmp_csr_bank.sv
      - hdl/pmp_unit.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/pmp_unit_sva.sv
      - testbench/pmp_unit_monitor.sv
      - testbench/pmp_unit_tb.sv

/* testbench/pmp_unit_tb.sv */
// Testbench for the PMP unit. Applies a table of CSR and access rows at one row per clock
// and lets the monitor compare the outputs against each row.
`timescale 1ns/1ps
`include "pmp_macros.svh"

module pmp_unit_tb;

  import pmp_pkg::*;

  typedef struct packed {
    logic [8*12-1:0] name;
    pmp_csr_req_t    csr;
    logic [31:0]     daddr;
    logic            ren;
    logic            wen;
    logic [31:0]     iaddr;
    logic            xen;
    priv_e           priv;
    logic            mprv;
    priv_e           mpp;
    logic            chk_rd;  // Compare read data on this row
    pmp_addr_t       rdata;
    logic            ack;
    pmp_fault_t      fault;
  } row_t;

  localparam int RESET_CYCLES = 4;

  logic       CLK;
  logic       nRST;
  row_t       cur;    // Row currently on the DUT inputs
  logic       check;
  row_t       tbl[$];
  int         cycles = 0;
  int         limit;
  int         errors;
  int         checks;
  pmp_addr_t  csr_rdata;
  logic       csr_ack;
  pmp_fault_t fault;

  pmp_unit dut0 (
    .CLK         (CLK),
    .nRST        (nRST),
    .i_csr_req   (cur.csr),
    .o_csr_rdata (csr_rdata),
    .o_csr_ack   (csr_ack),
    .i_daddr     (cur.daddr),
    .i_ren       (cur.ren),
    .i_wen       (cur.wen),
    .i_iaddr     (cur.iaddr),
    .i_xen       (cur.xen),
    .i_priv      (cur.priv),
    .i_mprv      (cur.mprv),
    .i_mpp       (cur.mpp),
    .o_fault     (fault)
  );

  pmp_unit_monitor u_monitor (
    .CLK         (CLK),
    .i_check     (check),
    .i_name      (cur.name),
    .i_chk_rd    (cur.chk_rd),
    .i_exp_rdata (cur.rdata),
    .i_exp_ack   (cur.ack),
    .i_exp_fault (cur.fault),
    .i_rdata     (csr_rdata),
    .i_ack       (csr_ack),
    .i_fault     (fault),
    .o_errors    (errors),
    .o_checks    (checks)
  );

  bind pmp_unit pmp_unit_sva sva0 (
    .CLK       (CLK),
    .nRST      (nRST),
    .i_csr_req (i_csr_req),
    .i_xen     (i_xen),
    .i_ack     (o_csr_ack),
    .i_fault   (o_fault)
  );

  // CSR write to a PMP register with no access in flight
  function automatic row_t write_row(input logic [8*12-1:0] nm, input logic [11:0] a,
                                     input logic [31:0] d);
    row_t r;
    r = '0;
    r.name = nm;
    r.csr = '{active: 1'b1, addr: a, wdata: d};
    r.priv = M_MODE;
    r.ack = 1'b1;
    return r;
  endfunction

  function automatic row_t read_row(input logic [8*12-1:0] nm, input logic [11:0] a,
                                    input logic [31:0] exp_rd, input logic exp_ack);
    row_t r;
    r = '0;
    r.name = nm;
    r.csr.addr = a;
    r.priv = M_MODE;
    r.chk_rd = 1'b1;
    r.rdata = exp_rd;
    r.ack = exp_ack;
    return r;
  endfunction

  // CSR address stays at 0, so ack and read data must be low
  function automatic row_t access_row(input logic [8*12-1:0] nm, input logic [31:0] da,
                                      input logic rd, input logic wr, input logic [31:0] ia,
                                      input logic xe, input priv_e p, input logic mprv,
                                      input priv_e mpp, input logic [2:0] f);
    row_t r;
    r = '0;
    r.name = nm;
    r.daddr = da;
    r.ren = rd;
    r.wen = wr;
    r.iaddr = ia;
    r.xen = xe;
    r.priv = p;
    r.mprv = mprv;
    r.mpp = mpp;
    r.chk_rd = 1'b1;
    r.fault = pmp_fault_t'(f);  // {store, load, fetch}
    return r;
  endfunction

  task automatic build_table();
    // Reset state and the CSR map
    for (int a = 0; a < `PMP_CFG_REGS; a++) begin
      tbl.push_back(read_row("rst_cfg", 12'(`PMP_CFG_BASE + a), 32'h0, 1'b1));
    end
    for (int a = 0; a < `PMP_ENTRIES; a++) begin
      tbl.push_back(read_row("rst_addr", 12'(`PMP_ADDR_BASE + a), 32'h0, 1'b1));
    end
    tbl.push_back(read_row("map_3a4", 12'h3A4, 32'h0, 1'b0));
    tbl.push_back(read_row("map_3c0", 12'h3C0, 32'h0, 1'b0));
    tbl.push_back(access_row("rst_u_ld", 'h1000, 1, 0, 0, 0, U_MODE, 0, U_MODE, 3'b010));
    // WARL cleanup of reserved bits and W without R
    tbl.push_back(write_row("warl_wr", 12'h3A3, 32'h6506_6362));
    tbl.push_back(read_row("warl_rd", 12'h3A3, 32'h0504_0300, 1'b1));
    // Entry 1 TOR 0x1000-0x1FFF R, 2 NA4 0x3000 RW, 3 NAPOT 0x4000 4K RWX, 4 NAPOT 16K R
    tbl.push_back(write_row("a0_wr", 12'h3B0, 32'h400));
    tbl.push_back(write_row("a1_wr", 12'h3B1, 32'h800));
    tbl.push_back(write_row("a2_wr", 12'h3B2, 32'hC00));
    tbl.push_back(write_row("a3_wr", 12'h3B3, 32'h11FF));
    tbl.push_back(write_row("a4_wr", 12'h3B4, 32'h17FF));
    tbl.push_back(write_row("a5_wr", 12'h3B5, 32'h2400));
    tbl.push_back(write_row("cfg0_wr", 12'h3A0, 32'h1F13_0900));
    tbl.push_back(write_row("cfg1_wr", 12'h3A1, 32'h0000_0019));
    tbl.push_back(read_row("cfg0_rd", 12'h3A0, 32'h1F13_0900, 1'b1));
    tbl.push_back(read_row("a3_rd", 12'h3B3, 32'h11FF, 1'b1));
    // Region matching
    tbl.push_back(access_row("tor_in_ld", 'h1800, 1, 0, 0, 0, U_MODE, 0, U_MODE, 3'b000));
    tbl.push_back(access_row("tor_top_ld", 'h2000, 1, 0, 0, 0, U_MODE, 0, U_MODE, 3'b010));
    tbl.push_back(access_row("tor_low_ld", 'h0FFC, 1, 0, 0, 0, U_MODE, 0, U_MODE, 3'b010));
    tbl.push_back(access_row("tor_st", 'h1800, 0, 1, 0, 0, U_MODE, 0, U_MODE, 3'b100));
    tbl.push_back(access_row("na4_st", 'h3000, 0, 1, 0, 0, U_MODE, 0, U_MODE, 3'b000));
    tbl.push_back(access_row("na4_out_st", 'h3004, 0, 1, 0, 0, U_MODE, 0, U_MODE, 3'b100));
    tbl.push_back(access_row("napot_fetch", 0, 0, 0, 'h4800, 1, U_MODE, 0, U_MODE, 3'b000));
    tbl.push_back(access_row("tor_fetch", 0, 0, 0, 'h1800, 1, U_MODE, 0, U_MODE, 3'b001));
    tbl.push_back(access_row("ovl_st_lo", 'h4100, 0, 1, 0, 0, U_MODE, 0, U_MODE, 3'b000));
    tbl.push_back(access_row("ovl_st_hi", 'h5000, 0, 1, 0, 0, U_MODE, 0, U_MODE, 3'b100));
    tbl.push_back(access_row("s_miss_ld", 'h8000, 1, 0, 0, 0, S_MODE, 0, U_MODE, 3'b010));
    tbl.push_back(access_row("st_fetch", 'h5000, 0, 1, 'h1800, 1, U_MODE, 0, U_MODE, 3'b100));
    // Privilege and MPRV
    tbl.push_back(access_row("m_ld_miss", 'h8000, 1, 0, 0, 0, M_MODE, 0, U_MODE, 3'b000));
    tbl.push_back(access_row("m_st_unlock", 'h1800, 0, 1, 0, 0, M_MODE, 0, U_MODE, 3'b000));
    tbl.push_back(access_row("mprv_ld", 'h8000, 1, 0, 'h8000, 1, M_MODE, 1, U_MODE, 3'b010));
    tbl.push_back(access_row("mprv_fetch", 0, 0, 0, 'h8000, 1, M_MODE, 1, U_MODE, 3'b000));
    // Entry 5 locked TOR R over 0x5FFC-0x8FFF freezes itself and pmpaddr4
    tbl.push_back(write_row("lock_wr", 12'h3A1, 32'h0000_8919));
    tbl.push_back(read_row("lock_rd", 12'h3A1, 32'h0000_8919, 1'b1));
    tbl.push_back(access_row("m_st_lock", 'h8800, 0, 1, 0, 0, M_MODE, 0, U_MODE, 3'b100));
    tbl.push_back(access_row("m_ld_lock", 'h8800, 1, 0, 0, 0, M_MODE, 0, U_MODE, 3'b000));
    tbl.push_back(write_row("lk_cfg_wr", 12'h3A1, 32'h0000_0F1B));
    tbl.push_back(read_row("lk_cfg_rd", 12'h3A1, 32'h0000_891B, 1'b1));
    tbl.push_back(write_row("lk_a5_wr", 12'h3B5, 32'h3000));
    tbl.push_back(read_row("lk_a5_rd", 12'h3B5, 32'h2400, 1'b1));
    tbl.push_back(write_row("tor_a4_wr", 12'h3B4, 32'h0));
    tbl.push_back(read_row("tor_a4_rd", 12'h3B4, 32'h17FF, 1'b1));
    tbl.push_back(write_row("free_a6_wr", 12'h3B6, 32'h1234));
    tbl.push_back(read_row("free_a6_rd", 12'h3B6, 32'h1234, 1'b1));
    tbl.push_back(access_row("new_w_st", 'h5000, 0, 1, 0, 0, U_MODE, 0, U_MODE, 3'b000));
  endtask

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  // Run limit scales with the table
  always @(posedge CLK) begin
    cycles++;
    if (cycles >= limit) begin
      $display("Timeout: the table did not finish within %0d cycles", limit);
      $display("TB FAILED");
      $finish;
    end
  end

  initial begin
    cur   = '0;
    check = 1'b0;
    nRST  = 1'b0;
    build_table();
    limit = 2 * tbl.size() + RESET_CYCLES;
    repeat (RESET_CYCLES) @(posedge CLK);
    #1 nRST = 1'b1;
    foreach (tbl[k]) begin
      @(posedge CLK);
      #1;
      cur   = tbl[k];
      check = 1'b1;
    end
    @(posedge CLK);
    #1;
    check = 1'b0;
    cur   = '0;
    $display("Checks %0d, value errors %0d, assertion failures %0d",
             checks, errors, dut0.sva0.failures);
    if (errors == 0 && dut0.sva0.failures == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* testbench/pmp_unit_monitor.sv */
// Compares the PMP unit outputs with the expected values of the current row.
// Samples on the falling edge, between the drive points.
`timescale 1ns/1ps

module pmp_unit_monitor (
  input  logic                CLK,
  input  logic                i_check,
  input  logic [8*12-1:0]     i_name,
  input  logic                i_chk_rd,
  input  pmp_pkg::pmp_addr_t  i_exp_rdata,
  input  logic                i_exp_ack,
  input  pmp_pkg::pmp_fault_t i_exp_fault,
  input  pmp_pkg::pmp_addr_t  i_rdata,
  input  logic                i_ack,
  input  pmp_pkg::pmp_fault_t i_fault,
  output int                  o_errors,
  output int                  o_checks
);

  import pmp_pkg::*;

  int errors = 0;
  int checks = 0;

  assign o_errors = errors;
  assign o_checks = checks;

  always @(negedge CLK) begin
    if (i_check) begin
      checks++;
      if (i_chk_rd && i_rdata !== i_exp_rdata) begin
        errors++;
        $display("Fail %s rdata: expected %h, actual %h", i_name, i_exp_rdata, i_rdata);
      end
      if (i_ack !== i_exp_ack) begin
        errors++;
        $display("Fail %s ack: expected %b, actual %b", i_name, i_exp_ack, i_ack);
      end
      if (i_fault !== i_exp_fault) begin
        errors++;  // Bits are store, load, fetch
        $display("Fail %s fault: expected %b, actual %b", i_name, i_exp_fault, i_fault);
      end
    end
  end

endmodule

/* testbench/pmp_unit_sva.sv */
// Concurrent checks bound into the PMP unit on fault routing and the CSR ack map
`timescale 1ns/1ps

module pmp_unit_sva (
  input logic                  CLK,
  input logic                  nRST,
  input pmp_pkg::pmp_csr_req_t i_csr_req,
  input logic                  i_xen,
  input logic                  i_ack,
  input pmp_pkg::pmp_fault_t   i_fault
);

  import pmp_pkg::*;

  int   failures = 0;
  logic in_map;

  assign in_map = (i_csr_req.addr >= 12'h3A0 && i_csr_req.addr <= 12'h3A3) ||
                  (i_csr_req.addr >= 12'h3B0 && i_csr_req.addr <= 12'h3BF);

  // A fetch fault needs a fetch and never joins a data fault
  a_fetch_alone: assert property (@(posedge CLK) disable iff (!nRST)
    i_fault.fetch |-> i_xen && !(i_fault.store || i_fault.load))
    else begin
      failures++;
      $error("Fetch fault without a fetch or together with a data fault");
    end

  a_ack_map: assert property (@(posedge CLK) disable iff (!nRST)
    !in_map |-> !i_ack)
    else begin
      failures++;
      $error("CSR ack high for an address outside the PMP map");
    end

endmodule

/* hdl/pmp_unit.sv */
// PMP top level: CSR bank plus data and fetch checkers.
// Faults are combinational; CSR writes land one clock after the strobe.
`timescale 1ns/1ps
`include "pmp_macros.svh"

module pmp_unit (
  input  logic                  CLK,
  input  logic                  nRST,
  input  pmp_pkg::pmp_csr_req_t i_csr_req,
  output pmp_pkg::pmp_addr_t    o_csr_rdata,
  output logic                  o_csr_ack,
  input  logic [`PMP_XLEN-1:0]  i_daddr,
  input  logic                  i_ren,
  input  logic                  i_wen,
  input  logic [`PMP_XLEN-1:0]  i_iaddr,
  input  logic                  i_xen,
  input  pmp_pkg::priv_e        i_priv,
  input  logic                  i_mprv,
  input  pmp_pkg::priv_e        i_mpp,
  output pmp_pkg::pmp_fault_t   o_fault
);

  import pmp_pkg::*;

  pmp_entry_cfg_t [`PMP_ENTRIES-1:0] cfg;
  pmp_addr_t      [`PMP_ENTRIES-1:0] pmpaddr;
  pmp_access_t                       d_req;
  pmp_access_t                       i_req;
  priv_e                             d_priv;
  logic                              d_fault;
  logic                              i_fault;

  pmp_csr_bank u_csr (
    .CLK     (CLK),
    .nRST    (nRST),
    .i_req   (i_csr_req),
    .o_rdata (o_csr_rdata),
    .o_ack   (o_csr_ack),
    .o_cfg   (cfg),
    .o_addr  (pmpaddr)
  );

  assign d_req  = '{r: i_ren, w: i_wen, x: 1'b0};
  assign i_req  = '{r: 1'b0, w: 1'b0, x: i_xen};
  assign d_priv = i_mprv ? i_mpp : i_priv;  // MPRV applies to loads and stores only

  // Word compare, byte offset bits drop out
  pmp_access_check u_dcheck (
    .i_addr    ({2'b00, i_daddr[`PMP_XLEN-1:2]}),
    .i_req     (d_req),
    .i_priv    (d_priv),
    .i_cfg     (cfg),
    .i_pmpaddr (pmpaddr),
    .o_fault   (d_fault)
  );

  pmp_access_check u_icheck (
    .i_addr    ({2'b00, i_iaddr[`PMP_XLEN-1:2]}),
    .i_req     (i_req),
    .i_priv    (i_priv),
    .i_cfg     (cfg),
    .i_pmpaddr (pmpaddr),
    .o_fault   (i_fault)
  );

  // A data fault takes precedence over a fetch fault
  always_comb begin
    o_fault = '0;
    if (d_fault) begin
      o_fault.store = i_wen;
      o_fault.load  = i_ren;
    end else if (i_fault) begin
      o_fault.fetch = 1'b1;
    end
  end

endmodule

/* hdl/pmp_csr_bank.sv */
// pmpcfg0-3 and pmpaddr0-15 with WARL cleanup and the lock rules.
// Readback and ack decode combinationally from the CSR address.
`timescale 1ns/1ps
`include "pmp_macros.svh"

module pmp_csr_bank (
  input  logic                                      CLK,
  input  logic                                      nRST,
  input  pmp_pkg::pmp_csr_req_t                     i_req,
  output pmp_pkg::pmp_addr_t                        o_rdata,
  output logic                                      o_ack,
  output pmp_pkg::pmp_entry_cfg_t [`PMP_ENTRIES-1:0] o_cfg,
  output pmp_pkg::pmp_addr_t      [`PMP_ENTRIES-1:0] o_addr
);

  import pmp_pkg::*;

  localparam logic [11:0] CFG_BASE  = `PMP_CFG_BASE;
  localparam logic [11:0] ADDR_BASE = `PMP_ADDR_BASE;

  pmp_cfg_word_t [`PMP_CFG_REGS-1:0] cfg_q;
  pmp_addr_t     [`PMP_ENTRIES-1:0]  addr_q;

  logic                              cfg_sel;
  logic                              addr_sel;
  logic [$clog2(`PMP_CFG_REGS)-1:0]  cfg_idx;
  logic [$clog2(`PMP_ENTRIES)-1:0]   addr_idx;
  logic [$clog2(`PMP_ENTRIES)-1:0]   next_idx;
  pmp_cfg_word_t                     cfg_new;
  logic                              addr_wr_ok;

  // Address decode
  assign cfg_sel  = (i_req.addr[11:2] == CFG_BASE[11:2]);   // 0x3A0-0x3A3
  assign addr_sel = (i_req.addr[11:4] == ADDR_BASE[11:4]);  // 0x3B0-0x3BF
  assign cfg_idx  = i_req.addr[1:0];
  assign addr_idx = i_req.addr[3:0];
  assign next_idx = addr_idx + 4'd1;

  // Per-entry view of the packed cfg registers
  always_comb begin
    for (int i = 0; i < `PMP_ENTRIES; i++) begin
      o_cfg[i] = cfg_q[i / 4][i % 4];
    end
  end

  assign o_addr = addr_q;

  // WARL cleanup of an incoming cfg word, locked bytes keep their value
  always_comb begin
    cfg_new = pmp_cfg_word_t'(i_req.wdata);
    for (int b = 0; b < 4; b++) begin
      cfg_new[b].reserved = 2'b00;
      if (!cfg_new[b].r) begin
        cfg_new[b].w = 1'b0;  // W without R is reserved
      end
      if (cfg_q[cfg_idx][b].lock) begin
        cfg_new[b] = cfg_q[cfg_idx][b];
      end
    end
  end

  // A locked TOR entry also freezes the pmpaddr below it
  always_comb begin
    addr_wr_ok = !o_cfg[addr_idx].lock;
    if (addr_idx != 4'hF && o_cfg[next_idx].lock && o_cfg[next_idx].mode == TOR) begin
      addr_wr_ok = 1'b0;
    end
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      cfg_q  <= '0;  // All entries OFF
      addr_q <= '0;
    end else if (i_req.active) begin
      if (cfg_sel) begin
        cfg_q[cfg_idx] <= cfg_new;
      end
      if (addr_sel && addr_wr_ok) begin
        addr_q[addr_idx] <= i_req.wdata;
      end
    end
  end

  // Readback, ack is a level on the address alone
  always_comb begin
    o_ack   = 1'b1;
    o_rdata = '0;
    if (cfg_sel) begin
      o_rdata = pmp_addr_t'(cfg_q[cfg_idx]);
    end else if (addr_sel) begin
      o_rdata = addr_q[addr_idx];
    end else begin
      o_ack = 1'b0;  // Not a PMP register
    end
  end

endmodule

/* hdl/pmp_access_check.sv */
// Permission check for one access port against all PMP entries.
// Lowest-numbered matching entry decides; fully combinational.
`timescale 1ns/1ps
`include "pmp_macros.svh"

module pmp_access_check (
  input  pmp_pkg::pmp_addr_t                         i_addr,
  input  pmp_pkg::pmp_access_t                       i_req,
  input  pmp_pkg::priv_e                             i_priv,
  input  pmp_pkg::pmp_entry_cfg_t [`PMP_ENTRIES-1:0] i_cfg,
  input  pmp_pkg::pmp_addr_t      [`PMP_ENTRIES-1:0] i_pmpaddr,
  output logic                                       o_fault
);

  import pmp_pkg::*;

  pmp_addr_t [`PMP_ENTRIES-1:0] prev_addr;
  logic      [`PMP_ENTRIES-1:0] hit;
  pmp_entry_cfg_t               match_cfg;
  logic                         match_found;
  logic                         any_req;
  logic                         denied;

  // Lower TOR bound of each entry, zero below entry 0
  assign prev_addr = {i_pmpaddr[`PMP_ENTRIES-2:0], {`PMP_XLEN{1'b0}}};

  for (genvar i = 0; i < `PMP_ENTRIES; i++) begin : g_match
    pmp_region_match u_match (
      .i_addr (i_addr),
      .i_cfg  (i_cfg[i]),
      .i_base (i_pmpaddr[i]),
      .i_prev (prev_addr[i]),
      .o_hit  (hit[i])
    );
  end

  // Walk down so the lowest index wins
  always_comb begin
    match_found = 1'b0;
    match_cfg   = '0;
    for (int i = `PMP_ENTRIES - 1; i >= 0; i--) begin
      if (hit[i]) begin
        match_found = 1'b1;
        match_cfg   = i_cfg[i];
      end
    end
  end

  assign any_req = i_req.r | i_req.w | i_req.x;
  assign denied  = (i_req.r & ~match_cfg.r) |
                   (i_req.w & ~match_cfg.w) |
                   (i_req.x & ~match_cfg.x);

  always_comb begin
    if (i_priv != M_MODE) begin
      // S and U need a matching entry that grants every request
      o_fault = any_req && (!match_found || denied);
    end else begin
      o_fault = match_found && match_cfg.lock && denied;  // Only locked entries bind M
    end
  end

endmodule

/* hdl/pmp_region_match.sv */
// Checks one word address against the region of one PMP entry.
// Used once per entry inside each access checker.
`timescale 1ns/1ps

module pmp_region_match (
  input  pmp_pkg::pmp_addr_t      i_addr,
  input  pmp_pkg::pmp_entry_cfg_t i_cfg,
  input  pmp_pkg::pmp_addr_t      i_base,
  input  pmp_pkg::pmp_addr_t      i_prev,
  output logic                    o_hit
);

  import pmp_pkg::*;

  pmp_addr_t napot_mask;

  // Trailing ones of pmpaddr give the region size.
  // base ^ (base + 1) sets exactly those ones and the zero above them,
  // so its complement keeps only the bits that must compare equal
  assign napot_mask = ~(i_base ^ (i_base + 1'b1));

  always_comb begin
    unique case (i_cfg.mode)
      OFF: begin
        o_hit = 1'b0;
      end
      TOR: begin
        o_hit = (i_addr >= i_prev) && (i_addr < i_base);  // [prev, base)
      end
      NA4: begin
        o_hit = (i_addr == i_base);
      end
      NAPOT: begin
        o_hit = ((i_addr ^ i_base) & napot_mask) == '0;
      end
      default: begin
        o_hit = 1'b0;
      end
    endcase
  end

endmodule

/* hdl/pmp_pkg.sv */
// Types shared by the PMP CSR bank, the region matchers and the checkers
`include "pmp_macros.svh"

package pmp_pkg;

  // Address matching mode, field A of pmpcfg
  typedef enum logic [1:0] {
    OFF   = 2'd0,
    TOR   = 2'd1,
    NA4   = 2'd2,
    NAPOT = 2'd3
  } pmp_mode_e;

  // One entry's configuration byte, L in bit 7 and R in bit 0
  typedef struct packed {
    logic      lock;
    logic [1:0] reserved;
    pmp_mode_e mode;
    logic      x;
    logic      w;
    logic      r;
  } pmp_entry_cfg_t;

  typedef pmp_entry_cfg_t [3:0] pmp_cfg_word_t; // Entry 0 in the low byte

  typedef logic [`PMP_XLEN-1:0] pmp_addr_t; // Physical address bits 33:2

  typedef enum logic [1:0] {
    U_MODE = 2'd0,
    S_MODE = 2'd1,
    M_MODE = 2'd3
  } priv_e;

  // Permissions asked for by one access
  typedef struct packed {
    logic r;
    logic w;
    logic x;
  } pmp_access_t;

  typedef struct packed {
    logic                 active; // Write strobe
    logic [11:0]          addr;
    logic [`PMP_XLEN-1:0] wdata;
  } pmp_csr_req_t;

  typedef struct packed {
    logic store;
    logic load;
    logic fetch;
  } pmp_fault_t;

endpackage

/* hdl/pmp_macros.svh */
// Sizes and CSR map of the PMP unit, included by the package and the RTL
// that sizes its arrays from the entry count
`ifndef PMP_MACROS_SVH
`define PMP_MACROS_SVH

// Entries and the pmpcfg registers that pack them, four per register
`define PMP_ENTRIES   16
`define PMP_CFG_REGS  4

// CSR addresses of pmpcfg0 and pmpaddr0
`define PMP_CFG_BASE  12'h3A0
`define PMP_ADDR_BASE 12'h3B0

// RV32 word width
`define PMP_XLEN      32

`endif
